// ==== hw/periph_pkg.sv ====
`default_nettype none

package periph_pkg;

    // ==================================================
    // Bus geometry
    // ==================================================
    localparam int unsigned DATA_WIDTH = 32;
    localparam int unsigned SLOT_COUNT = 8;

    // Slot indices taken from address bits 30:28.
    localparam logic [2:0] SLOT_RAM   = 3'd0;
    localparam logic [2:0] SLOT_GPIO  = 3'd1;
    localparam logic [2:0] SLOT_TIMER = 3'd2;

    // Returned by reads of the unmapped slots.
    localparam logic [DATA_WIDTH-1:0] BUS_ERROR_DATA = 32'hBAD0_0BAD;

    // ==================================================
    // Peripheral sizes and registers
    // ==================================================
    localparam int unsigned RAM_WORDS      = 64;
    localparam int unsigned RAM_INDEX_BITS = $clog2(RAM_WORDS);
    localparam int unsigned GPIO_WIDTH     = 16;

    typedef enum logic [1:0] {
        GPIO_OUT = 2'd0,
        GPIO_IN  = 2'd1
    } gpio_reg_e;

    typedef enum logic [1:0] {
        TIMER_CTRL   = 2'd0,
        TIMER_LOAD   = 2'd1,
        TIMER_COUNT  = 2'd2,
        TIMER_STATUS = 2'd3
    } timer_reg_e;

    typedef enum logic {
        TIMER_IDLE,
        TIMER_RUN
    } timer_state_e;

endpackage

`default_nettype wire

// ==== hw/peripheral_bus.sv ====
`timescale 1ns/1ps
`default_nettype none

module peripheral_bus (
    input  logic                              clk_i,
    input  logic                              reset_i,

    // Master side.
    input  logic [periph_pkg::DATA_WIDTH-1:0] addr_i,
    input  logic                              write_request_i,
    input  logic                              read_request_i,
    output logic                              response_o,
    output logic [periph_pkg::DATA_WIDTH-1:0] read_data_o,

    // Slot 0, scratch RAM.
    output logic                              ram_write_request_o,
    output logic                              ram_read_request_o,
    input  logic                              ram_response_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] ram_read_data_i,

    // Slot 1, GPIO.
    output logic                              gpio_write_request_o,
    output logic                              gpio_read_request_o,
    input  logic                              gpio_response_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] gpio_read_data_i,

    // Slot 2, timer.
    output logic                              timer_write_request_o,
    output logic                              timer_read_request_o,
    input  logic                              timer_response_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] timer_read_data_i
);

    import periph_pkg::*;

    logic [2:0]            slot;
    logic [SLOT_COUNT-1:0] slot_select;
    logic                  slot_unmapped;
    logic                  unmapped_request;
    logic                  unmapped_response_q;

    assign slot          = addr_i[30:28];
    assign slot_select   = SLOT_COUNT'(1) << slot;
    assign slot_unmapped = ~(slot_select[SLOT_RAM] | slot_select[SLOT_GPIO]
                             | slot_select[SLOT_TIMER]);

    // ==================================================
    // Request steering
    // ==================================================
    assign ram_write_request_o   = slot_select[SLOT_RAM] & write_request_i;
    assign ram_read_request_o    = slot_select[SLOT_RAM] & read_request_i;
    assign gpio_write_request_o  = slot_select[SLOT_GPIO] & write_request_i;
    assign gpio_read_request_o   = slot_select[SLOT_GPIO] & read_request_i;
    assign timer_write_request_o = slot_select[SLOT_TIMER] & write_request_i;
    assign timer_read_request_o  = slot_select[SLOT_TIMER] & read_request_i;

    // Slots 3 to 7 get a local one-cycle response; writes there are dropped.
    assign unmapped_request = slot_unmapped & (write_request_i | read_request_i);

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            unmapped_response_q <= 1'b0;
        end else begin
            unmapped_response_q <= unmapped_request & ~unmapped_response_q;
        end
    end

    // ==================================================
    // Response and read data return
    // ==================================================
    always_comb begin
        case (slot)
            SLOT_RAM: begin
                response_o  = ram_response_i;
                read_data_o = ram_read_data_i;
            end
            SLOT_GPIO: begin
                response_o  = gpio_response_i;
                read_data_o = gpio_read_data_i;
            end
            SLOT_TIMER: begin
                response_o  = timer_response_i;
                read_data_o = timer_read_data_i;
            end
            default: begin
                response_o  = unmapped_response_q;
                read_data_o = BUS_ERROR_DATA;
            end
        endcase
    end

    // Master must never issue a write and a read at once.
    assert property (@(posedge clk_i) disable iff (reset_i)
        !(write_request_i && read_request_i));

    // A peripheral only answers while the bus is steering a request to it.
    assert property (@(posedge clk_i) disable iff (reset_i)
        ram_response_i |-> (ram_write_request_o || ram_read_request_o));
    assert property (@(posedge clk_i) disable iff (reset_i)
        gpio_response_i |-> (gpio_write_request_o || gpio_read_request_o));
    assert property (@(posedge clk_i) disable iff (reset_i)
        timer_response_i |-> (timer_write_request_o || timer_read_request_o));

endmodule

`default_nettype wire

// ==== hw/scratch_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module scratch_ram (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] addr_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] write_data_i,
    input  logic                              write_request_i,
    input  logic                              read_request_i,
    output logic                              response_o,
    output logic [periph_pkg::DATA_WIDTH-1:0] read_data_o
);

    import periph_pkg::*;

    logic [DATA_WIDTH-1:0]     mem [RAM_WORDS];
    logic [RAM_WORDS-1:0]      word_valid_q;
    logic [RAM_INDEX_BITS-1:0] index;
    logic                      write_strobe;
    logic                      read_strobe;
    logic                      response_q;
    logic [DATA_WIDTH-1:0]     read_data_q;

    assign index = addr_i[RAM_INDEX_BITS+1:2];

    // A request is served once, on the edge that raises the response.
    assign write_strobe = write_request_i & ~response_q;
    assign read_strobe  = read_request_i & ~response_q;

    // Words not written since reset read back as zero.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            response_q   <= 1'b0;
            word_valid_q <= '0;
        end else begin
            response_q <= write_strobe | read_strobe;
            if (write_strobe) begin
                word_valid_q[index] <= 1'b1;
            end
        end
    end

    // ==================================================
    // Storage
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (write_strobe) begin
            mem[index] <= write_data_i;
        end
        if (read_strobe) begin
            read_data_q <= word_valid_q[index] ? mem[index] : '0;
        end
    end

    assign response_o  = response_q;
    assign read_data_o = read_data_q;

endmodule

`default_nettype wire

// ==== hw/gpio_port.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_port (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] addr_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] write_data_i,
    input  logic                              write_request_i,
    input  logic                              read_request_i,
    output logic                              response_o,
    output logic [periph_pkg::DATA_WIDTH-1:0] read_data_o,
    input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_in_i,
    output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_out_o
);

    import periph_pkg::*;

    gpio_reg_e             reg_sel;
    logic                  write_strobe;
    logic                  read_strobe;
    logic                  response_q;
    logic [DATA_WIDTH-1:0] read_data_q;
    logic [GPIO_WIDTH-1:0] out_q;
    logic [GPIO_WIDTH-1:0] sync_meta_q;
    logic [GPIO_WIDTH-1:0] sync_in_q;

    assign reg_sel      = gpio_reg_e'(addr_i[3:2]);
    assign write_strobe = write_request_i & ~response_q;
    assign read_strobe  = read_request_i & ~response_q;

    // ==================================================
    // Control and output register
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            response_q <= 1'b0;
            out_q      <= '0;
        end else begin
            response_q <= write_strobe | read_strobe;
            // GPIO_IN is read only.
            if (write_strobe && reg_sel == GPIO_OUT) begin
                out_q <= write_data_i[GPIO_WIDTH-1:0];
            end
        end
    end

    // Two-flop synchronizer on the pins.
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            sync_meta_q <= '0;
            sync_in_q   <= '0;
        end else begin
            sync_meta_q <= gpio_in_i;
            sync_in_q   <= sync_meta_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_strobe) begin
            case (reg_sel)
                GPIO_OUT: read_data_q <= DATA_WIDTH'(out_q);
                GPIO_IN:  read_data_q <= DATA_WIDTH'(sync_in_q);
                default:  read_data_q <= '0;
            endcase
        end
    end

    assign response_o  = response_q;
    assign read_data_o = read_data_q;
    assign gpio_out_o  = out_q;

endmodule

`default_nettype wire

// ==== hw/interval_timer.sv ====
`timescale 1ns/1ps
`default_nettype none

module interval_timer (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] addr_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] write_data_i,
    input  logic                              write_request_i,
    input  logic                              read_request_i,
    output logic                              response_o,
    output logic [periph_pkg::DATA_WIDTH-1:0] read_data_o,
    output logic                              irq_o
);

    import periph_pkg::*;

    timer_reg_e            reg_sel;
    timer_state_e          state_q;
    logic                  write_strobe;
    logic                  read_strobe;
    logic                  response_q;
    logic                  enable_q;
    logic                  expired_q;
    logic [DATA_WIDTH-1:0] load_q;
    logic [DATA_WIDTH-1:0] count_q;
    logic [DATA_WIDTH-1:0] read_data_q;

    assign reg_sel      = timer_reg_e'(addr_i[3:2]);
    assign write_strobe = write_request_i & ~response_q;
    assign read_strobe  = read_request_i & ~response_q;

    // ==================================================
    // Counter FSM and register writes
    // ==================================================
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            response_q <= 1'b0;
            state_q    <= TIMER_IDLE;
            enable_q   <= 1'b0;
            expired_q  <= 1'b0;
            load_q     <= '0;
            count_q    <= '0;
        end else begin
            response_q <= write_strobe | read_strobe;

            unique case (state_q)
                TIMER_IDLE: begin
                    if (enable_q) begin
                        state_q <= TIMER_RUN;
                        count_q <= load_q;
                    end
                end
                TIMER_RUN: begin
                    if (!enable_q) begin
                        state_q <= TIMER_IDLE;
                    end else if (count_q == '0) begin
                        expired_q <= 1'b1;
                        count_q   <= load_q;
                    end else begin
                        count_q <= count_q - 1'b1;
                    end
                end
            endcase

            // Bus writes take priority over the counter on the same edge.
            if (write_strobe) begin
                unique case (reg_sel)
                    TIMER_CTRL: enable_q <= write_data_i[0];
                    TIMER_LOAD: begin
                        load_q  <= write_data_i;
                        count_q <= write_data_i;
                    end
                    TIMER_COUNT: ;
                    TIMER_STATUS: begin
                        if (write_data_i[0]) begin
                            expired_q <= 1'b0;
                        end
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (read_strobe) begin
            unique case (reg_sel)
                TIMER_CTRL:   read_data_q <= DATA_WIDTH'(enable_q);
                TIMER_LOAD:   read_data_q <= load_q;
                TIMER_COUNT:  read_data_q <= count_q;
                TIMER_STATUS: read_data_q <= DATA_WIDTH'(expired_q);
            endcase
        end
    end

    assign response_o  = response_q;
    assign read_data_o = read_data_q;
    assign irq_o       = expired_q;

    // Reloads and LOAD writes keep the running count within LOAD.
    assert property (@(posedge clk_i) disable iff (reset_i)
        (state_q == TIMER_RUN) |-> (count_q <= load_q));

endmodule

`default_nettype wire

// ==== hw/periph_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_subsystem (
    input  logic                              clk_i,
    input  logic                              reset_i,

    // Master port.
    input  logic [periph_pkg::DATA_WIDTH-1:0] addr_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] write_data_i,
    input  logic                              write_request_i,
    input  logic                              read_request_i,
    output logic                              response_o,
    output logic [periph_pkg::DATA_WIDTH-1:0] read_data_o,

    // Pins.
    input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_in_i,
    output logic [periph_pkg::GPIO_WIDTH-1:0] gpio_out_o,
    output logic                              irq_o
);

    import periph_pkg::*;

    logic                  ram_write_request;
    logic                  ram_read_request;
    logic                  ram_response;
    logic [DATA_WIDTH-1:0] ram_read_data;

    logic                  gpio_write_request;
    logic                  gpio_read_request;
    logic                  gpio_response;
    logic [DATA_WIDTH-1:0] gpio_read_data;

    logic                  timer_write_request;
    logic                  timer_read_request;
    logic                  timer_response;
    logic [DATA_WIDTH-1:0] timer_read_data;

    // ==================================================
    // Bus
    // ==================================================
    peripheral_bus i_peripheral_bus (
        .clk_i                 (clk_i),
        .reset_i               (reset_i),
        .addr_i                (addr_i),
        .write_request_i       (write_request_i),
        .read_request_i        (read_request_i),
        .response_o            (response_o),
        .read_data_o           (read_data_o),
        .ram_write_request_o   (ram_write_request),
        .ram_read_request_o    (ram_read_request),
        .ram_response_i        (ram_response),
        .ram_read_data_i       (ram_read_data),
        .gpio_write_request_o  (gpio_write_request),
        .gpio_read_request_o   (gpio_read_request),
        .gpio_response_i       (gpio_response),
        .gpio_read_data_i      (gpio_read_data),
        .timer_write_request_o (timer_write_request),
        .timer_read_request_o  (timer_read_request),
        .timer_response_i      (timer_response),
        .timer_read_data_i     (timer_read_data)
    );

    // ==================================================
    // Peripherals, address and write data broadcast
    // ==================================================
    scratch_ram i_scratch_ram (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .addr_i          (addr_i),
        .write_data_i    (write_data_i),
        .write_request_i (ram_write_request),
        .read_request_i  (ram_read_request),
        .response_o      (ram_response),
        .read_data_o     (ram_read_data)
    );

    gpio_port i_gpio_port (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .addr_i          (addr_i),
        .write_data_i    (write_data_i),
        .write_request_i (gpio_write_request),
        .read_request_i  (gpio_read_request),
        .response_o      (gpio_response),
        .read_data_o     (gpio_read_data),
        .gpio_in_i       (gpio_in_i),
        .gpio_out_o      (gpio_out_o)
    );

    interval_timer i_interval_timer (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .addr_i          (addr_i),
        .write_data_i    (write_data_i),
        .write_request_i (timer_write_request),
        .read_request_i  (timer_read_request),
        .response_o      (timer_response),
        .read_data_o     (timer_read_data),
        .irq_o           (irq_o)
    );

endmodule

`default_nettype wire

// ==== testbench/periph_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module periph_checker (
    input  logic                              clk_i,
    input  logic                              reset_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] addr_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] write_data_i,
    input  logic                              write_request_i,
    input  logic                              read_request_i,
    input  logic                              response_i,
    input  logic [periph_pkg::DATA_WIDTH-1:0] read_data_i,
    input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_in_i,
    input  logic [periph_pkg::GPIO_WIDTH-1:0] gpio_out_i,
    input  logic                              irq_i,
    output int                                mismatch_count_o,
    output int                                handshake_count_o
);

    import periph_pkg::*;

    logic [DATA_WIDTH-1:0] shadow_ram [RAM_WORDS];
    logic [GPIO_WIDTH-1:0] shadow_gpio_out;
    logic                  shadow_enable;
    logic [DATA_WIDTH-1:0] shadow_load;
    logic                  request_now;
    logic                  request_prev;
    int                    request_age;
    int                    quiet_left;
    int                    i;
    int                    mismatch_count = 0;
    int                    handshake_count = 0;

    assign mismatch_count_o  = mismatch_count;
    assign handshake_count_o = handshake_count;

    // Expected read data from the address and the shadow state.
    function automatic logic [DATA_WIDTH-1:0] expected_read(input logic [DATA_WIDTH-1:0] addr);
        logic [1:0] reg_index;
        reg_index = addr[3:2];
        case (addr[30:28])
            SLOT_RAM: return shadow_ram[addr[7:2]];
            SLOT_GPIO: begin
                if (reg_index == GPIO_OUT) return DATA_WIDTH'(shadow_gpio_out);
                if (reg_index == GPIO_IN) return DATA_WIDTH'(gpio_in_i);
                return '0;
            end
            SLOT_TIMER: begin
                if (reg_index == TIMER_CTRL) return DATA_WIDTH'(shadow_enable);
                if (reg_index == TIMER_LOAD) return shadow_load;
                return '0;
            end
            default: return BUS_ERROR_DATA;
        endcase
    endfunction

    // ==================================================
    // Snoop and compare, away from the rising edge
    // ==================================================
    always @(negedge clk_i) begin
        if (reset_i) begin
            for (i = 0; i < RAM_WORDS; i++) begin
                shadow_ram[i] = '0;
            end
            shadow_gpio_out = '0;
            shadow_enable   = 1'b0;
            shadow_load     = '0;
            request_prev    = 1'b0;
            request_age     = 0;
            quiet_left      = 0;
        end else begin
            request_now = write_request_i | read_request_i;
            if (request_now && !request_prev) begin
                request_age = 0;
            end else if (request_now) begin
                request_age++;
            end

            if (response_i && !(request_now && request_age == 1)) begin
                handshake_count++;
                $display("Handshake error at %0t: response_o high without a request one cycle earlier",
                         $time);
            end
            if (request_now && request_age == 1 && !response_i) begin
                handshake_count++;
                $display("Handshake error at %0t: no response_o one cycle after the request rose",
                         $time);
            end

            // Writes land on the response edge.
            if (response_i && write_request_i) begin
                case (addr_i[30:28])
                    SLOT_RAM: shadow_ram[addr_i[7:2]] = write_data_i;
                    SLOT_GPIO: begin
                        if (addr_i[3:2] == GPIO_OUT) shadow_gpio_out = write_data_i[GPIO_WIDTH-1:0];
                    end
                    SLOT_TIMER: begin
                        if (addr_i[3:2] == TIMER_CTRL) shadow_enable = write_data_i[0];
                        if (addr_i[3:2] == TIMER_LOAD) shadow_load = write_data_i;
                        if (addr_i[3:2] == TIMER_STATUS && write_data_i[0]) begin
                            quiet_left = int'(shadow_load);
                        end
                    end
                    default: ;
                endcase
            end

            if (response_i && read_request_i) begin
                if (addr_i[30:28] == SLOT_TIMER && addr_i[3:2] == TIMER_COUNT) begin
                    if (read_data_i > shadow_load) begin
                        mismatch_count++;
                        $display("Mismatch at %0t: read_data_o expected <= %h, got %h",
                                 $time, shadow_load, read_data_i);
                    end
                end else if (read_data_i !== expected_read(addr_i)) begin
                    mismatch_count++;
                    $display("Mismatch at %0t: read_data_o expected %h, got %h (addr %h)",
                             $time, expected_read(addr_i), read_data_i, addr_i);
                end
            end

            if (gpio_out_i !== shadow_gpio_out) begin
                mismatch_count++;
                $display("Mismatch at %0t: gpio_out_o expected %h, got %h",
                         $time, shadow_gpio_out, gpio_out_i);
            end

            // After a STATUS clear the interrupt stays low for LOAD cycles.
            if (quiet_left > 0) begin
                if (irq_i !== 1'b0) begin
                    mismatch_count++;
                    $display("Mismatch at %0t: irq_o expected 0, got %b", $time, irq_i);
                end
                quiet_left--;
            end

            request_prev = request_now;
        end
    end

endmodule

`default_nettype wire

// ==== testbench/tb_periph_subsystem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_periph_subsystem;

    import periph_pkg::*;

    localparam int          CLOCK_HALF       = 50;
    localparam int          RESPONSE_TIMEOUT = 8;
    localparam int          PHASE_ONE_COUNT  = 150;
    localparam int          PHASE_TWO_COUNT  = 100;
    localparam logic [31:0] SEED             = 32'h1cd17720;

    logic                  clk_i;
    logic                  reset_i;
    logic [DATA_WIDTH-1:0] addr_i;
    logic [DATA_WIDTH-1:0] write_data_i;
    logic                  write_request_i;
    logic                  read_request_i;
    logic                  response_o;
    logic [DATA_WIDTH-1:0] read_data_o;
    logic [GPIO_WIDTH-1:0] gpio_in_i;
    logic [GPIO_WIDTH-1:0] gpio_out_o;
    logic                  irq_o;
    int                    mismatch_count;
    int                    handshake_count;
    int                    timeout_count;

    periph_subsystem i_periph_subsystem (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .addr_i          (addr_i),
        .write_data_i    (write_data_i),
        .write_request_i (write_request_i),
        .read_request_i  (read_request_i),
        .response_o      (response_o),
        .read_data_o     (read_data_o),
        .gpio_in_i       (gpio_in_i),
        .gpio_out_o      (gpio_out_o),
        .irq_o           (irq_o)
    );

    periph_checker i_periph_checker (
        .clk_i             (clk_i),
        .reset_i           (reset_i),
        .addr_i            (addr_i),
        .write_data_i      (write_data_i),
        .write_request_i   (write_request_i),
        .read_request_i    (read_request_i),
        .response_i        (response_o),
        .read_data_i       (read_data_o),
        .gpio_in_i         (gpio_in_i),
        .gpio_out_i        (gpio_out_o),
        .irq_i             (irq_o),
        .mismatch_count_o  (mismatch_count),
        .handshake_count_o (handshake_count)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLOCK_HALF) clk_i = ~clk_i;
    end

    // Bits outside the decoded fields are random, bit 31 included.
    function automatic logic [31:0] bus_addr(input logic [2:0] slot, input logic [5:0] word);
        logic [31:0] a;
        a        = $urandom;
        a[30:28] = slot;
        a[7:2]   = word;
        a[1:0]   = 2'b00;
        return a;
    endfunction

    function automatic logic [31:0] reg_addr(input logic [2:0] slot, input logic [1:0] reg_index);
        logic [3:0] spare;
        spare = 4'($urandom_range(0, 15));
        return bus_addr(slot, {spare, reg_index});
    endfunction

    // One transaction; called on a rising edge, returns on a rising edge.
    task automatic run_access(input logic is_write, input logic [31:0] addr,
                              input logic [31:0] data);
        int waited;
        addr_i          <= addr;
        write_data_i    <= data;
        write_request_i <= is_write;
        read_request_i  <= ~is_write;
        waited = 0;
        do begin
            @(posedge clk_i);
            waited++;
        end while (!response_o && waited < RESPONSE_TIMEOUT);
        if (!response_o) begin
            timeout_count++;
            $display("No response to the %s at address %h within %0d cycles",
                     is_write ? "write" : "read", addr, RESPONSE_TIMEOUT);
        end
        write_request_i <= 1'b0;
        read_request_i  <= 1'b0;
        @(posedge clk_i);
    endtask

    task automatic wait_for_irq(input int limit);
        int waited;
        waited = 0;
        while (!irq_o && waited < limit) begin
            @(posedge clk_i);
            waited++;
        end
        if (!irq_o) begin
            timeout_count++;
            $display("Timer interrupt did not rise within %0d cycles", limit);
        end
    endtask

    task automatic random_access();
        int         kind;
        logic       is_write;
        logic [2:0] slot;
        kind     = $urandom_range(0, 9);
        is_write = 1'($urandom_range(0, 1));
        slot     = 3'($urandom_range(3, SLOT_COUNT - 1));
        case (kind)
            0, 1, 2, 3: begin
                run_access(is_write, bus_addr(SLOT_RAM, 6'($urandom_range(0, RAM_WORDS - 1))),
                           $urandom);
            end
            4: run_access(1'b1, reg_addr(SLOT_GPIO, GPIO_OUT), $urandom);
            5: run_access(1'b0, reg_addr(SLOT_GPIO, GPIO_OUT), $urandom);
            6: begin
                // Pins settle through the synchronizer before the read.
                gpio_in_i <= GPIO_WIDTH'($urandom);
                repeat (3) @(posedge clk_i);
                run_access(1'b0, reg_addr(SLOT_GPIO, GPIO_IN), $urandom);
            end
            7: run_access(1'b0, reg_addr(SLOT_TIMER, 2'($urandom_range(0, 2))), $urandom);
            default: run_access(is_write, bus_addr(slot, 6'($urandom_range(0, 63))), $urandom);
        endcase
    endtask

    // ==================================================
    // Timer run, interrupt and clear
    // ==================================================
    task automatic timer_sequence(input int load_value);
        run_access(1'b1, reg_addr(SLOT_TIMER, TIMER_LOAD), 32'(load_value));
        run_access(1'b1, reg_addr(SLOT_TIMER, TIMER_CTRL), 32'd1);
        wait_for_irq(load_value + 4);
        repeat (3) run_access(1'b0, reg_addr(SLOT_TIMER, TIMER_COUNT), $urandom);
        run_access(1'b1, reg_addr(SLOT_TIMER, TIMER_CTRL), 32'd0);
        run_access(1'b1, reg_addr(SLOT_TIMER, TIMER_STATUS), 32'd1);
        repeat (load_value + 2) @(posedge clk_i);
    endtask

    initial begin
        int n;
        void'($urandom(SEED));
        addr_i          = '0;
        write_data_i    = '0;
        write_request_i = 1'b0;
        read_request_i  = 1'b0;
        gpio_in_i       = '0;
        reset_i         = 1'b1;
        timeout_count   = 0;
        repeat (2) @(posedge clk_i);
        reset_i <= 1'b0;
        @(posedge clk_i);

        for (n = 0; n < PHASE_ONE_COUNT; n++) begin
            random_access();
        end
        timer_sequence($urandom_range(4, 20));
        for (n = 0; n < PHASE_TWO_COUNT; n++) begin
            random_access();
        end
        timer_sequence($urandom_range(4, 20));

        $display("Errors: %0d mismatches, %0d handshake errors, %0d timeouts",
                 mismatch_count, handshake_count, timeout_count);
        if (mismatch_count == 0 && handshake_count == 0 && timeout_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
hw/periph_pkg.sv
hw/peripheral_bus.sv
hw/scratch_ram.sv
hw/gpio_port.sv
hw/interval_timer.sv
hw/periph_subsystem.sv
testbench/periph_checker.sv
testbench/tb_periph_subsystem.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_periph_subsystem
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

# Builds and runs the testbench; fails unless the pass line is printed.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)
